// ==== sim.f ====
+incdir+logic
+incdir+dv
logic/pix_pkg.sv
logic/pix_stream_if.sv
logic/pix_fifo.sv
logic/cam_capture.sv
logic/grey_convert.sv
logic/sys_control.sv
logic/pix_top.sv
dv/pix_tb.sv

// ==== Makefile ====
# Verilator build and run for the camera pixel pipeline
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= pix_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || \
		(echo "Simulation ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/pix_tb_tasks.svh ====
//------------------------------------------------------------
// Bookkeeping
//------------------------------------------------------------
task automatic start_test();
	test_errs = errors;
endtask

task automatic finish_test(input string name);
	tests_run++;
	if (errors != test_errs) begin
		tests_failed++;
		$display("Test %s: %0d errors", name, errors - test_errs);
	end else begin
		$display("Test %s: ok", name);
	end
endtask

task automatic idle(input int n);
	repeat (n) @(negedge clk_25MHz);
endtask

// Reference pixel from a camera byte pair
function automatic pix_pkg::rgb444_t expected_pixel(input logic [7:0] b0,
		input logic [7:0] b1, input pix_pkg::mode_e mode);
	pix_pkg::rgb444_t px;
	int               lum;
	px.r = b0[3:0];   // High nibble of byte 0 ignored
	px.g = b1[7:4];
	px.b = b1[3:0];
	if (mode == pix_pkg::MODE_GREY) begin
		lum  = (int'(px.r) + 2 * int'(px.g) + int'(px.b)) / 4;
		px.r = 4'(lum);
		px.g = 4'(lum);
		px.b = 4'(lum);
	end
	return px;
endfunction

//------------------------------------------------------------
// Stimulus and collection
//------------------------------------------------------------
// One vsync pulse then one href line of n_pix pixels
// Only the first keep pixels are expected at the output
task automatic send_frame(input int n_pix, input int keep, input int press_at,
		input bit rand_ready, input pix_pkg::mode_e mode);
	logic [7:0]         b0;
	logic [7:0]         b1;
	pix_pkg::pix_beat_t beat;
	@(negedge clk_25MHz);
	i_cam_vsync = 1'b1;
	idle(3);
	i_cam_vsync = 1'b0;
	exp_frames  = exp_frames + 8'd1;
	idle(4);  // Frame start and mode update settle
	check_mode("o_mode", o_mode, mode);
	check_count("o_frame_count", o_frame_count, exp_frames);
	for (int k = 0; k < 2 * n_pix; k++) begin
		if (press_at >= 0 && k == 2 * press_at) i_btn_mode = 1'b1;
		if (press_at >= 0 && k == 2 * press_at + 4) i_btn_mode = 1'b0;
		if (rand_ready) i_pix_ready = 1'($random(seed));
		i_cam_data = 8'($random(seed));
		i_cam_href = 1'b1;
		if (k % 2 == 0) begin
			b0 = i_cam_data;
		end else begin
			b1 = i_cam_data;
			if (k / 2 < keep) begin
				beat.pix = expected_pixel(b0, b1, mode);
				beat.sof = (k == 1);  // First pixel of the frame
				exp_q.push_back(beat);
			end
		end
		@(negedge clk_25MHz);
	end
	i_cam_href = 1'b0;
	i_cam_data = 8'h00;
	i_btn_mode = 1'b0;
endtask

task automatic wait_beats(input int n, input int limit);
	int waited;
	waited = 0;
	while (got_q.size() - got_rd < n && waited < limit) begin
		@(negedge clk_25MHz);
		waited++;
	end
	if (got_q.size() - got_rd < n) begin
		errors++;
		$display("Output stalled: %0d of %0d pixels after %0d cycles",
		         got_q.size() - got_rd, n, limit);
	end
endtask

// Release the output, drain, and compare against the model
task automatic compare_frame();
	int n_got;
	int n_cmp;
	@(negedge clk_25MHz);
	i_pix_ready = 1'b1;
	wait_beats(exp_q.size(), 300);
	idle(10);  // Room for surplus beats to show
	n_got = got_q.size() - got_rd;
	if (n_got != exp_q.size()) begin
		errors++;
		$display("Pixel count wrong: received %0d, expected %0d", n_got, exp_q.size());
	end
	n_cmp = (n_got < exp_q.size()) ? n_got : exp_q.size();
	for (int i = 0; i < n_cmp; i++) begin
		check_pix($sformatf("o_pix_data[%0d]", i), got_q[got_rd + i].pix, exp_q[i].pix);
		check_bit($sformatf("o_pix_sof[%0d]", i), got_q[got_rd + i].sof, exp_q[i].sof);
	end
	got_rd = got_q.size();
	exp_q.delete();
endtask

//------------------------------------------------------------
// Directed tests
//------------------------------------------------------------
task automatic test_reset_values();
	start_test();
	check_bit("o_pix_valid", o_pix_valid, 1'b0);
	check_bit("o_overflow", o_overflow, 1'b0);
	check_mode("o_mode", o_mode, pix_pkg::MODE_COLOR);
	check_count("o_frame_count", o_frame_count, 8'd0);
	finish_test("reset values");
endtask

task automatic test_colour_passthrough();
	start_test();
	send_frame(10, 10, -1, 1'b0, pix_pkg::MODE_COLOR);
	compare_frame();
	check_bit("o_overflow", o_overflow, 1'b0);
	finish_test("colour passthrough");
endtask

// Frame fits the buffer, so random stalls lose nothing
task automatic test_back_pressure();
	start_test();
	send_frame(12, 12, -1, 1'b1, pix_pkg::MODE_COLOR);
	compare_frame();
	check_bit("o_overflow", o_overflow, 1'b0);
	finish_test("back-pressure");
endtask

task automatic test_grey_switch();
	start_test();
	send_frame(8, 8, 3, 1'b0, pix_pkg::MODE_COLOR);  // Press mid-frame
	compare_frame();
	check_mode("o_mode", o_mode, pix_pkg::MODE_COLOR);  // Still pending
	send_frame(8, 8, -1, 1'b0, pix_pkg::MODE_GREY);
	compare_frame();
	finish_test("greyscale switch");
endtask

// FIFO plus grey register hold DEPTH + 1, the rest is dropped
task automatic test_overflow();
	start_test();
	i_pix_ready = 1'b0;
	send_frame(DEPTH + 5, DEPTH + 1, -1, 1'b0, pix_pkg::MODE_GREY);
	idle(4);
	check_bit("o_overflow", o_overflow, 1'b1);
	compare_frame();
	check_bit("o_overflow", o_overflow, 1'b1);  // Sticky
	finish_test("overflow");
endtask

task automatic test_toggle_back();
	start_test();
	i_btn_mode = 1'b1;
	idle(2);
	i_btn_mode = 1'b0;
	idle(2);
	check_mode("o_mode", o_mode, pix_pkg::MODE_GREY);  // Waits for vsync
	send_frame(10, 10, -1, 1'b0, pix_pkg::MODE_COLOR);
	compare_frame();
	finish_test("toggle back");
endtask

// ==== dv/pix_tb.sv ====
`timescale 1ns/1ps
`include "pix_cfg.svh"

// Directed testbench for the camera to display pixel pipeline
module pix_tb;

	//------------------------------------------------------------
	// Run limits
	//------------------------------------------------------------
	localparam int TEST_CYCLES    = 600;                    // Longest test
	localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES + 400;  // Six tests plus reset
	localparam int DEPTH          = `PIX_FIFO_DEPTH;

	// DUT ports
	logic               clk_25MHz;
	logic               db_rstn;
	logic               i_cam_vsync;
	logic               i_cam_href;
	logic [7:0]         i_cam_data;
	logic               i_btn_mode;
	logic               i_pix_ready;
	logic               o_pix_valid;
	pix_pkg::rgb444_t   o_pix_data;
	logic               o_pix_sof;
	pix_pkg::mode_e     o_mode;
	logic [7:0]         o_frame_count;
	logic               o_overflow;

	// Scoreboard
	pix_pkg::pix_beat_t exp_q [$];      // Model beats for the current frame
	pix_pkg::pix_beat_t got_q [$];      // Every beat taken at the output
	int                 got_rd;         // First unchecked output beat
	logic [7:0]         exp_frames;     // Vsync falls sent so far
	int                 seed;
	int                 errors;
	int                 tests_run;
	int                 tests_failed;
	int                 test_errs;      // Error count at test start
	int                 cycle_count = 0;

	pix_top i_dut (
		.clk_25MHz     (clk_25MHz    ),
		.db_rstn       (db_rstn      ),
		.i_cam_vsync   (i_cam_vsync  ),
		.i_cam_href    (i_cam_href   ),
		.i_cam_data    (i_cam_data   ),
		.i_btn_mode    (i_btn_mode   ),
		.i_pix_ready   (i_pix_ready  ),
		.o_pix_valid   (o_pix_valid  ),
		.o_pix_data    (o_pix_data   ),
		.o_pix_sof     (o_pix_sof    ),
		.o_mode        (o_mode       ),
		.o_frame_count (o_frame_count),
		.o_overflow    (o_overflow   )
	);

	always #20 clk_25MHz = ~clk_25MHz;  // 25 MHz

	// Hard stop on a hung test
	always @(posedge clk_25MHz) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	// Output monitor, one entry per valid/ready transfer
	always @(posedge clk_25MHz) begin : out_mon
		pix_pkg::pix_beat_t beat;
		if (db_rstn && o_pix_valid && i_pix_ready) begin
			beat.pix = o_pix_data;
			beat.sof = o_pix_sof;
			got_q.push_back(beat);
		end
	end

	//------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------
	task automatic check_pix(input string name, input pix_pkg::rgb444_t got,
	                         input pix_pkg::rgb444_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_mode(input string name, input pix_pkg::mode_e got,
	                          input pix_pkg::mode_e exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] got,
	                           input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	`include "pix_tb_tasks.svh"

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial begin
		clk_25MHz    = 1'b0;
		db_rstn      = 1'b0;   // Held over the first two edges
		i_cam_vsync  = 1'b0;
		i_cam_href   = 1'b0;
		i_cam_data   = 8'h00;
		i_btn_mode   = 1'b0;
		i_pix_ready  = 1'b1;
		seed         = 32'hcc1a;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errs    = 0;
		got_rd       = 0;
		exp_frames   = 8'd0;
		repeat (2) @(negedge clk_25MHz);
		db_rstn = 1'b1;

		test_reset_values();
		test_colour_passthrough();
		test_back_pressure();
		test_grey_switch();
		test_overflow();
		test_toggle_back();

		$display("Tests run %0d, tests with errors %0d, errors %0d",
		         tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== logic/pix_top.sv ====
`timescale 1ns/1ps

// Camera capture, stream FIFO, grey stage and control
// All on clk_25MHz
module pix_top (
	input  logic                clk_25MHz,
	input  logic                db_rstn,

	// Camera byte stream
	input  logic                i_cam_vsync,
	input  logic                i_cam_href,
	input  logic [7:0]          i_cam_data,

	// Controls
	input  logic                i_btn_mode,

	// Pixel output, valid/ready
	input  logic                i_pix_ready,
	output logic                o_pix_valid,
	output pix_pkg::rgb444_t    o_pix_data,
	output logic                o_pix_sof,

	// Status
	output pix_pkg::mode_e      o_mode,
	output logic [7:0]          o_frame_count,
	output logic                o_overflow
);

	//------------------------------------------------------------
	// Internal streams and wires
	//------------------------------------------------------------
	pix_stream_if cap_s ();   // Capture to FIFO
	pix_stream_if fifo_s ();  // FIFO to grey stage

	logic               frame_start;
	pix_pkg::pix_beat_t out_beat;

	// Flatten the output beat
	assign o_pix_data = out_beat.pix;
	assign o_pix_sof  = out_beat.sof;

	//------------------------------------------------------------
	// Blocks
	//------------------------------------------------------------
	cam_capture cap_i (
		.clk_25MHz     (clk_25MHz    ),
		.db_rstn       (db_rstn      ),
		.i_cam_vsync   (i_cam_vsync  ),
		.i_cam_href    (i_cam_href   ),
		.i_cam_data    (i_cam_data   ),
		.out           (cap_s.src    ),
		.o_frame_start (frame_start  ),
		.o_overflow    (o_overflow   )
	);

	pix_fifo #(
		.T (pix_pkg::pix_beat_t)
	) fifo_i (
		.clk_25MHz (clk_25MHz  ),
		.db_rstn   (db_rstn    ),
		.wr        (cap_s.snk  ),
		.rd        (fifo_s.src )
	);

	grey_convert grey_i (
		.clk_25MHz (clk_25MHz   ),
		.db_rstn   (db_rstn     ),
		.in        (fifo_s.snk  ),
		.i_mode    (o_mode      ),  // Same mode as reported
		.o_valid   (o_pix_valid ),
		.i_ready   (i_pix_ready ),
		.o_beat    (out_beat    )
	);

	sys_control ctrl_i (
		.clk_25MHz     (clk_25MHz     ),
		.db_rstn       (db_rstn       ),
		.i_btn_mode    (i_btn_mode    ),
		.i_frame_start (frame_start   ),
		.o_mode        (o_mode        ),
		.o_frame_count (o_frame_count )
	);

endmodule

// ==== logic/sys_control.sv ====
`timescale 1ns/1ps

// Mode button and frame bookkeeping
// Mode changes only land on a frame start
module sys_control (
	input  logic            clk_25MHz,
	input  logic            db_rstn,
	input  logic            i_btn_mode,     // Already clean, same clock
	input  logic            i_frame_start,  // Pulse from capture
	output pix_pkg::mode_e  o_mode,
	output logic [7:0]      o_frame_count
);

	//------------------------------------------------------------
	// Button edge and pending toggle
	//------------------------------------------------------------
	logic btn_q;
	logic btn_rise;
	logic toggle_pend;  // Press seen, waiting for frame start

	assign btn_rise = i_btn_mode & ~btn_q;

	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			btn_q         <= 1'b0;
			toggle_pend   <= 1'b0;
			o_mode        <= pix_pkg::MODE_COLOR;
			o_frame_count <= 8'd0;
		end else begin
			btn_q <= i_btn_mode;

			if (i_frame_start) begin
				// Apply any held toggle at the boundary
				if (toggle_pend) begin
					o_mode <= (o_mode == pix_pkg::MODE_COLOR) ?
					          pix_pkg::MODE_GREY : pix_pkg::MODE_COLOR;
				end
				// A press in the same cycle waits for the next frame
				toggle_pend   <= btn_rise;
				o_frame_count <= o_frame_count + 8'd1;  // Wraps at 255
			end else if (btn_rise) begin
				toggle_pend <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/grey_convert.sv ====
`timescale 1ns/1ps

// Colour passthrough or greyscale, one output register
// Takes a new beat when the register is empty or drains this cycle
module grey_convert (
	input  logic                clk_25MHz,
	input  logic                db_rstn,
	pix_stream_if.snk           in,        // From FIFO
	input  pix_pkg::mode_e      i_mode,
	output logic                o_valid,
	input  logic                i_ready,
	output pix_pkg::pix_beat_t  o_beat
);

	//------------------------------------------------------------
	// Greyscale arithmetic
	//------------------------------------------------------------
	logic [5:0]         grey_sum;  // r + 2g + b, at most 60
	logic [3:0]         grey_nib;
	pix_pkg::pix_beat_t conv;      // Beat after mode applied
	logic               take;

	assign grey_sum = {2'b00, in.data.pix.r}
	                + {1'b0, in.data.pix.g, 1'b0}
	                + {2'b00, in.data.pix.b};
	assign grey_nib = grey_sum[5:2];  // Divide by four, truncate

	always_comb begin
		conv = in.data;
		if (i_mode == pix_pkg::MODE_GREY) begin
			conv.pix.r = grey_nib;
			conv.pix.g = grey_nib;
			conv.pix.b = grey_nib;
		end
	end

	//------------------------------------------------------------
	// Output register
	//------------------------------------------------------------
	assign in.ready = ~o_valid | i_ready;
	assign take     = in.valid & in.ready;

	// Payload holds while stalled
	always_ff @(posedge clk_25MHz) begin
		if (take) o_beat <= conv;
	end

	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			o_valid <= 1'b0;
		end else if (take) begin
			o_valid <= 1'b1;
		end else if (i_ready) begin
			o_valid <= 1'b0;  // Drained, nothing behind it
		end
	end

endmodule

// ==== logic/cam_capture.sv ====
`timescale 1ns/1ps
`include "pix_cfg.svh"

// OV7670 style byte stream to RGB444 pixel beats
// Camera bytes arrive already on clk_25MHz
module cam_capture (
	input  logic       clk_25MHz,
	input  logic       db_rstn,
	input  logic       i_cam_vsync,    // High during frame blanking
	input  logic       i_cam_href,     // High on active bytes
	input  logic [7:0] i_cam_data,
	pix_stream_if.src  out,            // Pixel beats toward FIFO
	output logic       o_frame_start,  // One cycle per vsync fall
	output logic       o_overflow      // Sticky drop flag
);

	//------------------------------------------------------------
	// Frame timing
	//------------------------------------------------------------
	logic vsync_q;     // Previous vsync sample
	logic vsync_fall;
	logic first_pix;   // Next pixel opens a frame

	assign vsync_fall = vsync_q & ~i_cam_vsync;

	//------------------------------------------------------------
	// Byte pairing
	//------------------------------------------------------------
	logic              byte_phase;  // 0 first byte, 1 second byte
	logic [3:0]        r_nib;       // Held red nibble from first byte
	logic [`PIX_W-1:0] asm_pix;     // r from byte 0, g and b from byte 1
	logic              beat_valid;
	pix_pkg::pix_beat_t beat_q;

	assign asm_pix = {r_nib, i_cam_data};

	assign out.valid = beat_valid;
	assign out.data  = beat_q;

	// Payload, loaded on each completed pair
	always_ff @(posedge clk_25MHz) begin
		if (i_cam_href && byte_phase) begin
			beat_q.pix <= pix_pkg::rgb444_t'(asm_pix);
			beat_q.sof <= first_pix;
		end
		if (i_cam_href && !byte_phase) begin
			r_nib <= i_cam_data[3:0];  // Upper nibble of byte 0 unused
		end
	end

	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			vsync_q       <= 1'b0;
			o_frame_start <= 1'b0;
			first_pix     <= 1'b0;
			byte_phase    <= 1'b0;
			beat_valid    <= 1'b0;
			o_overflow    <= 1'b0;
		end else begin
			vsync_q       <= i_cam_vsync;
			o_frame_start <= vsync_fall;  // Lags the sampled fall by one

			// Phase restarts on every line
			if (i_cam_href) byte_phase <= ~byte_phase;
			else            byte_phase <= 1'b0;

			// Single cycle beat, FIFO either takes it or it is lost
			beat_valid <= i_cam_href & byte_phase;

			if (vsync_fall)
				first_pix <= 1'b1;
			else if (i_cam_href && byte_phase)
				first_pix <= 1'b0;  // sof consumed by this pixel

			// Full FIFO drops the beat
			if (beat_valid && !out.ready) o_overflow <= 1'b1;
		end
	end

endmodule

// ==== logic/pix_fifo.sv ====
`timescale 1ns/1ps
`include "pix_cfg.svh"

// First-word-fall-through stream FIFO
// Head word sits on rd.data whenever the FIFO holds anything
module pix_fifo #(
	parameter type T     = pix_pkg::pix_beat_t,
	parameter int  DEPTH = `PIX_FIFO_DEPTH
) (
	input  logic       clk_25MHz,
	input  logic       db_rstn,
	pix_stream_if.snk  wr,         // Write side
	pix_stream_if.src  rd          // Read side
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	//------------------------------------------------------------
	// Storage and pointers
	//------------------------------------------------------------
	T                  mem [DEPTH];  // Payload only, no reset
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;        // Words held
	logic              wr_en;
	logic              rd_en;

	// Pointer step with wrap at DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	assign wr.ready = (count != CNT_W'(DEPTH));  // Ready unless full
	assign rd.valid = (count != '0);             // Valid unless empty
	assign rd.data  = mem[rd_ptr];               // Fall-through head

	assign wr_en = wr.valid & wr.ready;
	assign rd_en = rd.valid & rd.ready;

	// Write port
	always_ff @(posedge clk_25MHz) begin
		if (wr_en) begin
			mem[wr_ptr] <= T'(wr.data);
		end
	end

	//------------------------------------------------------------
	// Control state
	//------------------------------------------------------------
	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) wr_ptr <= ptr_next(wr_ptr);
			if (rd_en) rd_ptr <= ptr_next(rd_ptr);

			// Simultaneous push and pop leaves count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/pix_stream_if.sv ====
`timescale 1ns/1ps

// Valid/ready pixel stream between pipeline blocks
// Beat moves on a clock edge with valid and ready both high
interface pix_stream_if;

	logic                valid;  // Source has a beat
	logic                ready;  // Sink can take it
	pix_pkg::pix_beat_t  data;   // Pixel and sof

	// Producer side
	modport src (
		output valid,
		output data,
		input  ready
	);

	// Consumer side
	modport snk (
		input  valid,
		input  data,
		output ready
	);

endinterface

// ==== logic/pix_pkg.sv ====
package pix_pkg;

	//------------------------------------------------------------
	// Pixel and stream types
	//------------------------------------------------------------

	// RGB444 pixel, r in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444_t;

	// One stream beat, pixel plus start of frame marker
	typedef struct packed {
		rgb444_t pix;
		logic    sof;  // First pixel of a frame
	} pix_beat_t;

	// Display mode, colour after reset
	typedef enum logic {
		MODE_COLOR = 1'b0,
		MODE_GREY  = 1'b1
	} mode_e;

endpackage

// ==== logic/pix_cfg.svh ====
`ifndef PIX_CFG_SVH
`define PIX_CFG_SVH

//------------------------------------------------------------
// Pixel stream sizing
//------------------------------------------------------------

// Stream FIFO capacity in pixels
// With the grey stage register the pipeline buffers one more
`define PIX_FIFO_DEPTH 16

// RGB444 pixel width
// Must agree with pix_pkg::rgb444_t
`define PIX_W 12

// Camera bytes per pixel in RGB444 mode
// First byte carries r in the low nibble
// Second byte carries g and b

`endif
